// ==== verilog.f ====
rtl/bhf_pkg.sv
rtl/pipe_register.sv
rtl/bhf_classify.sv
rtl/bhf_mul_raw.sv
rtl/bhf_round.sv
rtl/bhf_fmul.sv
tb/bhf_fmul_properties.sv
tb/tb_bhf_fmul.sv

// ==== Makefile ====
# Verilator flow for the bfloat16 multiplier testbench
VERILATOR   ?= verilator
TOP         ?= tb_bhf_fmul
FLIST       ?= verilog.f
LOG         ?= sim.log
SEED        ?= 46813
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_bhf_fmul.sv ====
// Directed tests against an integer model; assumes flush-to-zero underflow and canonical NaN output
`default_nettype none

module tb_bhf_fmul #(
    parameter int SEED = 46813
);
    timeunit 1ns;
    timeprecision 1ps;
    import bhf_pkg::*;

    localparam int LAT         = MUL_LATENCY + RND_LATENCY;
    localparam int N_RAND      = 40;
    localparam int N_SPEC      = 12;
    localparam int N_STALL     = 60;
    localparam int N_VECTORS   = 6 * N_RAND + N_SPEC * N_SPEC + 5 * 20 + 5 * 20 + N_STALL + 13;
    localparam int CYCLE_LIMIT = 3 * N_VECTORS + 200;

    // Operand classes of the model
    localparam int K_ZERO = 0;
    localparam int K_NORM = 1;
    localparam int K_INF  = 2;
    localparam int K_QNAN = 3;
    localparam int K_SNAN = 4;

    localparam logic [2:0] MODES [6] = '{RM_RNE, RM_RTZ, RM_RDN, RM_RUP, RM_RMM, 3'd6};
    // Zeros, infinities, quiet and signaling NaNs, subnormals, two normals
    localparam logic [15:0] SPECIALS [N_SPEC] = '{16'h0000, 16'h8000, 16'h7F80, 16'hFF80,
        16'h7FC0, 16'hFFC5, 16'h7F81, 16'hFFA0, 16'h0041, 16'h8012, 16'h3FC0, 16'hC040};
    localparam logic [15:0] OV_A [4] = '{16'h7F7F, 16'hFF7F, 16'h7F00, 16'hFF00};
    localparam logic [15:0] OV_B [5] = '{16'h7F7F, 16'h4000, 16'hC000, 16'h4040, 16'h3F81};
    // 00B5 * 3F35 lands just below the smallest normal and rounds up under RNE
    localparam logic [15:0] UF_A [4] = '{16'h0080, 16'h8080, 16'h00B5, 16'h0100};
    localparam logic [15:0] UF_B [5] = '{16'h3F00, 16'h3F35, 16'hBF35, 16'h0080, 16'h3F7F};

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic [2:0]  frm;
    bf16_t       a;
    bf16_t       b;
    bf16_t       y;
    logic [4:0]  fflags;
    logic [21:0] expect_q [$];
    bf16_t       last_y;
    logic [4:0]  last_flags;
    int          cycle_count = 0;

    bhf_fmul uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .frm    (frm),
        .a      (a),
        .b      (b),
        .y      (y),
        .fflags (fflags)
    );

    bind bhf_fmul bhf_fmul_properties props (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .y      (y),
        .fflags (fflags)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic check_y(input bf16_t got, input bf16_t expected);
        if (got.bits !== expected.bits) begin
            $display("** Error y: got %h, expected %h", got.bits, expected.bits);
            abort_run();
        end
    endtask

    task automatic check_flags(input logic [4:0] got, input logic [4:0] expected);
        if (got !== expected) begin
            $display("** Error fflags: got %h, expected %h", got, expected);
            abort_run();
        end
    endtask

    function automatic int kind_of(input bf16_t v);
        if (v.f.exp == 8'h00) return K_ZERO;
        if (v.f.exp != 8'hFF) return K_NORM;
        if (v.f.man == 7'h00) return K_INF;
        return v.f.man[6] ? K_QNAN : K_SNAN;
    endfunction

    // Expected {y, fflags} for one product
    function automatic logic [20:0] model_mul(input bf16_t x, input bf16_t z,
                                              input logic [2:0] rm);
        int         ka;
        int         kb;
        int         p;
        int         e;
        int         shift;
        int         q;
        int         rem;
        int         half;
        logic       s;
        logic       nv;
        logic       inc;
        logic       to_inf;
        bf16_t      r;
        logic [4:0] fl;
        ka     = kind_of(x);
        kb     = kind_of(z);
        s      = x.f.sign ^ z.f.sign;
        r.bits = 16'h0000;
        fl     = 5'b0;
        nv = (ka == K_SNAN) || (kb == K_SNAN) || (ka == K_INF && kb == K_ZERO)
            || (ka == K_ZERO && kb == K_INF);
        if (ka >= K_QNAN || kb >= K_QNAN || nv) begin
            r.bits      = CANON_NAN;
            fl[FLAG_NV] = nv;
        end else if (ka == K_INF || kb == K_INF) begin
            r.f.sign = s;
            r.f.exp  = 8'hFF;
        end else if (ka == K_ZERO || kb == K_ZERO) begin
            r.f.sign = s;
        end else begin
            p     = (128 + int'(x.f.man)) * (128 + int'(z.f.man));
            e     = int'(x.f.exp) + int'(z.f.exp) - BIAS;
            shift = 7;
            if (p >= 32768) begin
                shift = 8;
                e     = e + 1;
            end
            q    = p >> shift;
            rem  = p % (1 << shift);
            half = 1 << (shift - 1);
            case (rm)
                RM_RTZ:  inc = 1'b0;
                RM_RDN:  inc = (rem != 0) && s;
                RM_RUP:  inc = (rem != 0) && !s;
                RM_RMM:  inc = rem >= half;
                default: inc = (rem > half) || (rem == half && q % 2 == 1);
            endcase
            if (inc) q = q + 1;
            if (q == 256) begin
                q = 128;
                e = e + 1;
            end
            if (e > 254) begin
                to_inf = !(rm == RM_RTZ || (rm == RM_RDN && !s) || (rm == RM_RUP && s));
                r.bits      = to_inf ? 16'h7F80 : 16'h7F7F;
                r.f.sign    = s;
                fl[FLAG_OF] = 1'b1;
                fl[FLAG_NX] = 1'b1;
            end else if (e < 1) begin
                r.f.sign    = s;
                fl[FLAG_UF] = 1'b1;
                fl[FLAG_NX] = 1'b1;
            end else begin
                r.f.sign    = s;
                r.f.exp     = e[7:0];
                r.f.man     = q[6:0];
                fl[FLAG_NX] = rem != 0;
            end
        end
        return {r.bits, fl};
    endfunction

    function automatic bf16_t random_normal();
        bf16_t v;
        v.f.sign = 1'($urandom);
        v.f.exp  = 8'(100 + $urandom % 55);
        v.f.man  = 7'($urandom);
        return v;
    endfunction

    // One clock from falling edge to falling edge
    task automatic run_cycle(input bf16_t a_in, input bf16_t b_in, input logic [2:0] rm,
                             input logic en);
        logic [21:0] entry;
        a      = a_in;
        b      = b_in;
        frm    = rm;
        enable = en;
        @(posedge clk);
        if (en) expect_q.push_back({1'b1, model_mul(a_in, b_in, rm)});
        @(negedge clk);
        if (!en) begin
            check_y(y, last_y);
            check_flags(fflags, last_flags);
        end else if (expect_q.size() == LAT) begin
            entry = expect_q.pop_front();
            if (entry[21]) begin
                check_y(y, entry[20:5]);
                check_flags(fflags, entry[4:0]);
            end
        end
        last_y     = y;
        last_flags = fflags;
    endtask

    task automatic apply_reset(input int n);
        rst_n  = 1'b0;
        enable = 1'b1;
        frm    = RM_RNE;
        a.bits = '0;
        b.bits = '0;
        repeat (n) @(posedge clk);
        @(negedge clk);
        check_y(y, 16'h0000);
        check_flags(fflags, 5'h00);
        // First result after reset comes from the cleared multiply stage
        expect_q.delete();
        repeat (LAT - 1) expect_q.push_back(22'h0);
        last_y     = y;
        last_flags = fflags;
        rst_n      = 1'b1;
    endtask

    task automatic test_normal_products();
        foreach (MODES[m]) begin
            repeat (N_RAND) run_cycle(random_normal(), random_normal(), MODES[m], 1'b1);
        end
    endtask

    task automatic test_special_values();
        for (int i = 0; i < N_SPEC; i++) begin
            for (int j = 0; j < N_SPEC; j++) begin
                run_cycle(SPECIALS[i], SPECIALS[j], 3'((i + j) % 5), 1'b1);
            end
        end
    endtask

    task automatic test_overflow();
        for (int m = 0; m < 5; m++) begin
            foreach (OV_A[i]) begin
                foreach (OV_B[j]) run_cycle(OV_A[i], OV_B[j], 3'(m), 1'b1);
            end
        end
    endtask

    task automatic test_underflow();
        for (int m = 0; m < 5; m++) begin
            foreach (UF_A[i]) begin
                foreach (UF_B[j]) run_cycle(UF_A[i], UF_B[j], 3'(m), 1'b1);
            end
        end
    endtask

    task automatic test_stall();
        int gap;
        for (int i = 0; i < N_STALL; i++) begin
            if ($urandom % 3 == 0) begin
                gap = 1 + $urandom % 2;
                // Inputs shown during a stall must be ignored
                repeat (gap) run_cycle(random_normal(), random_normal(), 3'($urandom % 5), 1'b0);
            end
            run_cycle(random_normal(), random_normal(), 3'($urandom % 5), 1'b1);
        end
    endtask

    task automatic test_reset_midstream();
        repeat (3) run_cycle(random_normal(), random_normal(), RM_RNE, 1'b1);
        apply_reset(2);
        repeat (10) run_cycle(random_normal(), random_normal(), 3'($urandom % 5), 1'b1);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n  = 1'b0;
        enable = 1'b0;
        frm    = RM_RNE;
        a.bits = '0;
        b.bits = '0;
        apply_reset(8);
        test_normal_products();
        test_special_values();
        test_overflow();
        test_underflow();
        test_stall();
        test_reset_midstream();
        // Flush the last products out of the pipeline
        repeat (LAT) run_cycle(16'h0000, 16'h0000, RM_RNE, 1'b1);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/bhf_fmul_properties.sv ====
// Port-level checks for bhf_fmul only; assumes synchronous active-low reset and a quiet-NaN-only output
`default_nettype none

module bhf_fmul_properties (
    input wire                 clk,
    input wire                 rst_n,
    input wire                 enable,
    input wire bhf_pkg::bf16_t y,
    input wire [4:0]           fflags
);
    timeunit 1ns;
    timeprecision 1ps;
    import bhf_pkg::*;

    // Both pipe registers clear on reset
    reset_clears_outputs: assert property (
        @(posedge clk) !rst_n |=> (y.bits == '0 && fflags == '0)
    ) else $error("outputs not zero after a reset cycle");

    // A frozen pipeline keeps its outputs
    stall_holds_outputs: assert property (
        @(posedge clk) disable iff (!rst_n) !enable |=> ($stable(y.bits) && $stable(fflags))
    ) else $error("outputs changed while enable was low");

    // A multiplier never divides by zero
    no_divide_by_zero: assert property (
        @(posedge clk) disable iff (!rst_n) !fflags[FLAG_DZ]
    ) else $error("DZ flag raised");

    nan_is_canonical: assert property (
        @(posedge clk) disable iff (!rst_n) (&y.f.exp && y.f.man != '0) |-> y.bits == CANON_NAN
    ) else $error("NaN on y is not the canonical quiet NaN");

endmodule

`default_nettype wire

// ==== rtl/bhf_fmul.sv ====
// Result after MUL_LATENCY + RND_LATENCY enabled cycles; enable low freezes every stage
`default_nettype none

module bhf_fmul (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  enable,
    input  wire  [2:0]           frm,
    input  wire bhf_pkg::bf16_t  a,
    input  wire bhf_pkg::bf16_t  b,
    output bhf_pkg::bf16_t       y,
    output logic [4:0]           fflags
);
    import bhf_pkg::*;

    logic                     a_sign, a_is_zero, a_is_inf, a_is_nan, a_is_snan;
    logic                     b_sign, b_is_zero, b_is_inf, b_is_nan, b_is_snan;
    logic [EXP_W-1:0]         a_exp, b_exp;
    logic [SIG_W-1:0]         a_sig, b_sig;
    logic                     s1_invalid, s1_is_nan, s1_is_inf, s1_is_zero, s1_sign;
    logic                     s2_invalid, s2_is_nan, s2_is_inf, s2_is_zero, s2_sign;
    logic signed [SEXP_W-1:0] s1_sexp, s2_sexp;
    logic [PROD_W-1:0]        s1_sig, s2_sig;
    logic [2:0]               s2_frm;
    bf16_t                    s2_y;
    logic [4:0]               s2_fflags;

    // Operand decode
    bhf_classify class_a (
        .op      (a),
        .sign    (a_sign),
        .exp     (a_exp),
        .sig     (a_sig),
        .is_zero (a_is_zero),
        .is_inf  (a_is_inf),
        .is_nan  (a_is_nan),
        .is_snan (a_is_snan)
    );

    bhf_classify class_b (
        .op      (b),
        .sign    (b_sign),
        .exp     (b_exp),
        .sig     (b_sig),
        .is_zero (b_is_zero),
        .is_inf  (b_is_inf),
        .is_nan  (b_is_nan),
        .is_snan (b_is_snan)
    );

    // Raw multiplication
    bhf_mul_raw multiplier (
        .a_sign    (a_sign),
        .a_exp     (a_exp),
        .a_sig     (a_sig),
        .a_is_zero (a_is_zero),
        .a_is_inf  (a_is_inf),
        .a_is_nan  (a_is_nan),
        .a_is_snan (a_is_snan),
        .b_sign    (b_sign),
        .b_exp     (b_exp),
        .b_sig     (b_sig),
        .b_is_zero (b_is_zero),
        .b_is_inf  (b_is_inf),
        .b_is_nan  (b_is_nan),
        .b_is_snan (b_is_snan),
        .invalid   (s1_invalid),
        .is_nan    (s1_is_nan),
        .is_inf    (s1_is_inf),
        .is_zero   (s1_is_zero),
        .sign      (s1_sign),
        .sexp      (s1_sexp),
        .sig       (s1_sig)
    );

    pipe_register #(
        .DATAW (5 + SEXP_W + PROD_W + 3),
        .DEPTH (MUL_LATENCY)
    ) pipe_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  ({s1_invalid, s1_is_nan, s1_is_inf, s1_is_zero, s1_sign,
                    s1_sexp, s1_sig, frm}),
        .data_out ({s2_invalid, s2_is_nan, s2_is_inf, s2_is_zero, s2_sign,
                    s2_sexp, s2_sig, s2_frm})
    );

    // Rounding and packing
    bhf_round rounding (
        .invalid (s2_invalid),
        .is_nan  (s2_is_nan),
        .is_inf  (s2_is_inf),
        .is_zero (s2_is_zero),
        .sign    (s2_sign),
        .sexp    (s2_sexp),
        .sig     (s2_sig),
        .frm     (s2_frm),
        .y       (s2_y),
        .fflags  (s2_fflags)
    );

    pipe_register #(
        .DATAW (FP_W + 5),
        .DEPTH (RND_LATENCY)
    ) pipe_rnd (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .data_in  ({s2_y.bits, s2_fflags}),
        .data_out ({y.bits, fflags})
    );

endmodule

`default_nettype wire

// ==== rtl/bhf_round.sv ====
// Combinational; no gradual underflow, results below the smallest normal flush to signed zero
`default_nettype none

module bhf_round (
    input  wire                              invalid,
    input  wire                              is_nan,
    input  wire                              is_inf,
    input  wire                              is_zero,
    input  wire                              sign,
    input  wire signed [bhf_pkg::SEXP_W-1:0] sexp,
    input  wire  [bhf_pkg::PROD_W-1:0]       sig,
    input  wire  [2:0]                       frm,
    output bhf_pkg::bf16_t                   y,
    output logic [4:0]                       fflags
);
    import bhf_pkg::*;

    logic                     norm_hi;
    logic [SIG_W-1:0]         kept;
    logic                     guard;
    logic                     sticky;
    logic                     inexact;
    logic                     rne_inc;
    logic                     inc;
    logic                     ovf_inf;
    logic [SIG_W:0]           rounded;
    logic [SIG_W-2:0]         man_r;
    logic signed [SEXP_W-1:0] exp_n;
    logic signed [SEXP_W-1:0] exp_r;
    logic                     overflow;
    logic                     underflow;

    // Product of normals lies in [1,4), so at most one bit of normalization
    assign norm_hi = sig[PROD_W-1];
    assign kept    = norm_hi ? sig[PROD_W-1 -: SIG_W] : sig[PROD_W-2 -: SIG_W];
    assign guard   = norm_hi ? sig[PROD_W-SIG_W-1] : sig[PROD_W-SIG_W-2];
    assign sticky  = norm_hi ? |sig[PROD_W-SIG_W-2:0] : |sig[PROD_W-SIG_W-3:0];
    assign exp_n   = sexp + $signed({{(SEXP_W-1){1'b0}}, norm_hi});
    assign inexact = guard | sticky;

    // Ties to even
    assign rne_inc = guard & (sticky | kept[0]);

    always_comb begin
        case (frm)
            RM_RNE: begin
                inc     = rne_inc;
                ovf_inf = 1'b1;
            end
            RM_RTZ: begin
                inc     = 1'b0;
                ovf_inf = 1'b0;
            end
            RM_RDN: begin
                inc     = inexact & sign;
                ovf_inf = sign;
            end
            RM_RUP: begin
                inc     = inexact & ~sign;
                ovf_inf = ~sign;
            end
            RM_RMM: begin
                inc     = guard;
                ovf_inf = 1'b1;
            end
            default: begin
                inc     = rne_inc;
                ovf_inf = 1'b1;
            end
        endcase
    end

    assign rounded = {1'b0, kept} + {{SIG_W{1'b0}}, inc};

    // A carry out leaves a zero fraction and bumps the exponent
    assign man_r = rounded[SIG_W-2:0];
    assign exp_r = exp_n + $signed({{(SEXP_W-1){1'b0}}, rounded[SIG_W]});

    assign overflow  = exp_r > (2 ** EXP_W - 2);
    assign underflow = exp_r < 1;

    always_comb begin
        y.bits = '0;
        fflags = '0;
        if (is_nan) begin
            y.bits          = CANON_NAN;
            fflags[FLAG_NV] = invalid;
        end else if (is_inf) begin
            y.f.sign = sign;
            y.f.exp  = '1;
        end else if (is_zero) begin
            y.f.sign = sign;
        end else if (overflow) begin
            y.f.sign        = sign;
            y.f.exp         = ovf_inf ? '1 : {{(EXP_W-1){1'b1}}, 1'b0};
            y.f.man         = ovf_inf ? '0 : '1;
            fflags[FLAG_OF] = 1'b1;
            fflags[FLAG_NX] = 1'b1;
        end else if (underflow) begin
            // Flush to signed zero
            y.f.sign        = sign;
            fflags[FLAG_UF] = 1'b1;
            fflags[FLAG_NX] = 1'b1;
        end else begin
            y.f.sign        = sign;
            y.f.exp         = exp_r[EXP_W-1:0];
            y.f.man         = man_r;
            fflags[FLAG_NX] = inexact;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bhf_mul_raw.sv ====
// Combinational; exact product and biased exponent sum, special cases resolved before rounding
`default_nettype none

module bhf_mul_raw (
    input  wire                               a_sign,
    input  wire  [bhf_pkg::EXP_W-1:0]         a_exp,
    input  wire  [bhf_pkg::SIG_W-1:0]         a_sig,
    input  wire                               a_is_zero,
    input  wire                               a_is_inf,
    input  wire                               a_is_nan,
    input  wire                               a_is_snan,
    input  wire                               b_sign,
    input  wire  [bhf_pkg::EXP_W-1:0]         b_exp,
    input  wire  [bhf_pkg::SIG_W-1:0]         b_sig,
    input  wire                               b_is_zero,
    input  wire                               b_is_inf,
    input  wire                               b_is_nan,
    input  wire                               b_is_snan,
    output logic                              invalid,
    output logic                              is_nan,
    output logic                              is_inf,
    output logic                              is_zero,
    output logic                              sign,
    output logic signed [bhf_pkg::SEXP_W-1:0] sexp,
    output logic [bhf_pkg::PROD_W-1:0]        sig
);
    import bhf_pkg::*;

    logic signed [SEXP_W-1:0] a_exp_s;
    logic signed [SEXP_W-1:0] b_exp_s;

    assign a_exp_s = $signed({{(SEXP_W-EXP_W){1'b0}}, a_exp});
    assign b_exp_s = $signed({{(SEXP_W-EXP_W){1'b0}}, b_exp});

    assign sign = a_sign ^ b_sign;
    assign sexp = a_exp_s + b_exp_s - SEXP_W'(BIAS);
    assign sig  = a_sig * b_sig;

    // Signaling NaN input or inf * 0
    assign invalid = a_is_snan | b_is_snan | (a_is_inf & b_is_zero) | (a_is_zero & b_is_inf);

    assign is_nan  = a_is_nan | b_is_nan | invalid;
    assign is_inf  = (a_is_inf | b_is_inf) & ~is_nan;
    assign is_zero = (a_is_zero | b_is_zero) & ~is_nan;

endmodule

`default_nettype wire

// ==== rtl/bhf_classify.sv ====
// Combinational; subnormal operands are reported as zero and carry a zero significand
`default_nettype none

module bhf_classify (
    input  wire bhf_pkg::bf16_t              op,
    output logic                             sign,
    output logic [bhf_pkg::EXP_W-1:0]        exp,
    output logic [bhf_pkg::SIG_W-1:0]        sig,
    output logic                             is_zero,
    output logic                             is_inf,
    output logic                             is_nan,
    output logic                             is_snan
);
    import bhf_pkg::*;

    logic exp_zero;
    logic exp_ones;
    logic man_zero;
    logic quiet_bit;

    assign exp_zero  = (op.f.exp == '0);
    assign exp_ones  = &op.f.exp;
    assign man_zero  = (op.f.man == '0);
    // MSB of the fraction marks a quiet NaN
    assign quiet_bit = op.bits[SIG_W-2];

    assign sign = op.f.sign;
    assign exp  = op.f.exp;

    // Implicit bit restored for normals only
    assign sig = exp_zero ? '0 : {1'b1, op.f.man};

    assign is_zero = exp_zero;
    assign is_inf  = exp_ones & man_zero;
    assign is_nan  = exp_ones & ~man_zero;
    assign is_snan = is_nan & ~quiet_bit;

endmodule

`default_nettype wire

// ==== rtl/pipe_register.sv ====
// Delay of DEPTH enabled cycles; DEPTH of zero is a pass-through; reset clears every stage
`default_nettype none

module pipe_register #(
    parameter int DATAW = 1,
    parameter int DEPTH = 1
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              enable,
    input  wire  [DATAW-1:0] data_in,
    output logic [DATAW-1:0] data_out
);

    if (DEPTH == 0) begin : g_passthru
        assign data_out = data_in;
    end else begin : g_regs
        logic [DATAW-1:0] stage_q [DEPTH];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                for (int i = 0; i < DEPTH; i++) begin
                    stage_q[i] <= '0;
                end
            end else if (enable) begin
                stage_q[0] <= data_in;
                for (int i = 1; i < DEPTH; i++) begin
                    stage_q[i] <= stage_q[i-1];
                end
            end
        end

        assign data_out = stage_q[DEPTH-1];
    end

endmodule

`default_nettype wire

// ==== rtl/bhf_pkg.sv ====
// bfloat16 only, IEEE encoding at the ports, subnormals flushed to zero; rounding codes follow RISC-V frm
`default_nettype none

package bhf_pkg;

    // Format widths
    localparam int EXP_W  = 8;
    localparam int SIG_W  = 8;
    localparam int FP_W   = 16;
    localparam int BIAS   = 127;

    // Raw product: exact significand product and signed exponent sum
    localparam int PROD_W = 2 * SIG_W;
    localparam int SEXP_W = EXP_W + 2;

    // Pipeline depths
    localparam int MUL_LATENCY = 1;
    localparam int RND_LATENCY = 1;

    // Rounding modes, codes 5 to 7 fall back to RNE
    localparam logic [2:0] RM_RNE = 3'd0;
    localparam logic [2:0] RM_RTZ = 3'd1;
    localparam logic [2:0] RM_RDN = 3'd2;
    localparam logic [2:0] RM_RUP = 3'd3;
    localparam logic [2:0] RM_RMM = 3'd4;

    // Bit positions in fflags
    localparam int FLAG_NV = 4;
    localparam int FLAG_DZ = 3;
    localparam int FLAG_OF = 2;
    localparam int FLAG_UF = 1;
    localparam int FLAG_NX = 0;

    localparam logic [FP_W-1:0] CANON_NAN = 16'h7FC0;

    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exp;
        logic [SIG_W-2:0] man;
    } bf16_fields_t;

    // Raw word or field view of the same 16 bits
    typedef union packed {
        logic [FP_W-1:0] bits;
        bf16_fields_t    f;
    } bf16_t;

endpackage

`default_nettype wire
